// File: hdl/debug_req_gate.sv
// Startup halt request gate
`timescale 1ns/100ps
`default_nettype none

module debug_req_gate #(
  parameter int unsigned DelayCycles = dmi_pkg::DELAY_CYCLES_DEFAULT
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic haltreq_i,
  output logic debug_req_o
);

  // At least one bit, even with no hold-off
  localparam int unsigned CntW = (DelayCycles > 0) ? $clog2(DelayCycles + 1) : 1;

  logic [CntW-1:0] cnt_q;
  logic            expired;

  assign expired = (cnt_q == '0);

  // Gives boot code time to run before debug can halt the core
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= CntW'(DelayCycles);
    end else if (!expired) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = haltreq_i & expired;

endmodule

`default_nettype wire

// File: hdl/dmi_data_ram.sv
// Debug data buffer RAM
`timescale 1ns/100ps
`default_nettype none

module dmi_data_ram (
  input  logic                            clk_i,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [dmi_pkg::DATA_IDX_W-1:0]  addr_i,
  input  logic [dmi_pkg::DMI_DATA_W-1:0]  wdata_i,
  output logic [dmi_pkg::DMI_DATA_W-1:0]  rdata_o
);

  logic [dmi_pkg::DMI_DATA_W-1:0] mem_q [dmi_pkg::DATA_WORDS];
  logic [dmi_pkg::DMI_DATA_W-1:0] rdata_q;

  // Read data only changes on a read, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem_q[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: hdl/dmi_harness_top.sv
// DMI debug harness top
`timescale 1ns/100ps
`default_nettype none

module dmi_harness_top #(
  parameter int unsigned DelayCycles = dmi_pkg::DELAY_CYCLES_DEFAULT
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            sel_jtag_i,

  // JTAG side source
  input  logic                            jtag_req_valid_i,
  input  logic [dmi_pkg::DMI_ADDR_W-1:0]  jtag_req_addr_i,
  input  logic [1:0]                      jtag_req_op_i,
  input  logic [dmi_pkg::DMI_DATA_W-1:0]  jtag_req_data_i,
  output logic                            jtag_req_ready_o,
  output logic                            jtag_resp_valid_o,
  output logic [dmi_pkg::DMI_DATA_W-1:0]  jtag_resp_data_o,
  output logic [1:0]                      jtag_resp_code_o,
  input  logic                            jtag_resp_ready_i,

  // Simulated DTM side source
  input  logic                            dtm_req_valid_i,
  input  logic [dmi_pkg::DMI_ADDR_W-1:0]  dtm_req_addr_i,
  input  logic [1:0]                      dtm_req_op_i,
  input  logic [dmi_pkg::DMI_DATA_W-1:0]  dtm_req_data_i,
  output logic                            dtm_req_ready_o,
  output logic                            dtm_resp_valid_o,
  output logic [dmi_pkg::DMI_DATA_W-1:0]  dtm_resp_data_o,
  output logic [1:0]                      dtm_resp_code_o,
  input  logic                            dtm_resp_ready_i,

  output logic                            dmactive_o,
  output logic                            debug_req_o
);

  logic haltreq;

  dmi_if jtag_dmi ();
  dmi_if dtm_dmi ();
  dmi_if tgt_dmi ();

  // ----------------------------------------------------------------------
  // Port to channel wiring
  // ----------------------------------------------------------------------
  assign jtag_dmi.req_valid  = jtag_req_valid_i;
  assign jtag_dmi.req_addr   = jtag_req_addr_i;
  assign jtag_dmi.req_op     = dmi_pkg::dtm_op_e'(jtag_req_op_i);
  assign jtag_dmi.req_data   = jtag_req_data_i;
  assign jtag_dmi.resp_ready = jtag_resp_ready_i;
  assign jtag_req_ready_o    = jtag_dmi.req_ready;
  assign jtag_resp_valid_o   = jtag_dmi.resp_valid;
  assign jtag_resp_data_o    = jtag_dmi.resp_data;
  assign jtag_resp_code_o    = jtag_dmi.resp_code;

  assign dtm_dmi.req_valid   = dtm_req_valid_i;
  assign dtm_dmi.req_addr    = dtm_req_addr_i;
  assign dtm_dmi.req_op      = dmi_pkg::dtm_op_e'(dtm_req_op_i);
  assign dtm_dmi.req_data    = dtm_req_data_i;
  assign dtm_dmi.resp_ready  = dtm_resp_ready_i;
  assign dtm_req_ready_o     = dtm_dmi.req_ready;
  assign dtm_resp_valid_o    = dtm_dmi.resp_valid;
  assign dtm_resp_data_o     = dtm_dmi.resp_data;
  assign dtm_resp_code_o     = dtm_dmi.resp_code;

  // ----------------------------------------------------------------------
  // Debug path
  // ----------------------------------------------------------------------
  dmi_source_mux i_dmi_source_mux (
    .sel_jtag_i ( sel_jtag_i ),
    .jtag_s     ( jtag_dmi   ),
    .dtm_s      ( dtm_dmi    ),
    .tgt_m      ( tgt_dmi    )
  );

  dmi_target i_dmi_target (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .dmi_s      ( tgt_dmi    ),
    .haltreq_o  ( haltreq    ),
    .dmactive_o ( dmactive_o )
  );

  debug_req_gate #(
    .DelayCycles ( DelayCycles )
  ) i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .haltreq_i   ( haltreq     ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// File: hdl/dmi_if.sv
// DMI channel interface
`timescale 1ns/100ps
`default_nettype none

interface dmi_if;

  // Request channel
  logic                              req_valid;
  logic                              req_ready;
  logic [dmi_pkg::DMI_ADDR_W-1:0]    req_addr;
  dmi_pkg::dtm_op_e                  req_op;
  logic [dmi_pkg::DMI_DATA_W-1:0]    req_data;

  // Response channel
  logic                              resp_valid;
  logic                              resp_ready;
  logic [dmi_pkg::DMI_DATA_W-1:0]    resp_data;
  dmi_pkg::dmi_resp_e                resp_code;

  // Request source side
  modport master (
    output req_valid,
    output req_addr,
    output req_op,
    output req_data,
    output resp_ready,
    input  req_ready,
    input  resp_valid,
    input  resp_data,
    input  resp_code
  );

  // Debug target side
  modport slave (
    input  req_valid,
    input  req_addr,
    input  req_op,
    input  req_data,
    input  resp_ready,
    output req_ready,
    output resp_valid,
    output resp_data,
    output resp_code
  );

endinterface

`default_nettype wire

// File: hdl/dmi_pkg.sv
// DMI definitions
`default_nettype none

package dmi_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int unsigned DMI_ADDR_W = 7;
  localparam int unsigned DMI_DATA_W = 32;

  // Request operation, code 3 is reserved
  typedef enum logic [1:0] {
    OP_NOP   = 2'd0,
    OP_READ  = 2'd1,
    OP_WRITE = 2'd2
  } dtm_op_e;

  // Response code
  typedef enum logic [1:0] {
    RESP_SUCCESS = 2'd0,
    RESP_FAILED  = 2'd2
  } dmi_resp_e;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  localparam logic [DMI_ADDR_W-1:0] DMCONTROL_ADDR = 7'h10;
  localparam logic [DMI_ADDR_W-1:0] DATA_BASE_ADDR = 7'h20;
  localparam int unsigned           DATA_WORDS     = 16;
  localparam int unsigned           DATA_IDX_W     = $clog2(DATA_WORDS);

  // Debug control register layout
  typedef struct packed {
    logic        haltreq;
    logic [29:0] reserved;
    logic        dmactive;
  } dmcontrol_t;

  // One DMI word, either buffer data or control fields
  typedef union packed {
    logic [DMI_DATA_W-1:0] raw;
    dmcontrol_t            ctrl;
  } dmi_word_u;

  // Hold-off before a halt request may reach the core
  localparam int unsigned DELAY_CYCLES_DEFAULT = 500;

endpackage

`default_nettype wire

// File: hdl/dmi_source_mux.sv
// DMI request source selection
`timescale 1ns/100ps
`default_nettype none

module dmi_source_mux (
  input  logic sel_jtag_i,
  dmi_if.slave jtag_s,
  dmi_if.slave dtm_s,
  dmi_if.master tgt_m
);

  // ----------------------------------------------------------------------
  // Source to target
  // ----------------------------------------------------------------------
  assign tgt_m.req_valid  = sel_jtag_i ? jtag_s.req_valid  : dtm_s.req_valid;
  assign tgt_m.req_addr   = sel_jtag_i ? jtag_s.req_addr   : dtm_s.req_addr;
  assign tgt_m.req_op     = sel_jtag_i ? jtag_s.req_op     : dtm_s.req_op;
  assign tgt_m.req_data   = sel_jtag_i ? jtag_s.req_data   : dtm_s.req_data;
  assign tgt_m.resp_ready = sel_jtag_i ? jtag_s.resp_ready : dtm_s.resp_ready;

  // ----------------------------------------------------------------------
  // Target to JTAG side
  // ----------------------------------------------------------------------
  // Ready and response only reach the selected source
  assign jtag_s.req_ready  = sel_jtag_i & tgt_m.req_ready;
  assign jtag_s.resp_valid = sel_jtag_i & tgt_m.resp_valid;
  assign jtag_s.resp_data  = sel_jtag_i ? tgt_m.resp_data : '0;
  assign jtag_s.resp_code  = sel_jtag_i ? tgt_m.resp_code : dmi_pkg::RESP_SUCCESS;

  // ----------------------------------------------------------------------
  // Target to DTM side
  // ----------------------------------------------------------------------
  assign dtm_s.req_ready  = ~sel_jtag_i & tgt_m.req_ready;
  assign dtm_s.resp_valid = ~sel_jtag_i & tgt_m.resp_valid;
  assign dtm_s.resp_data  = sel_jtag_i ? '0 : tgt_m.resp_data;
  assign dtm_s.resp_code  = sel_jtag_i ? dmi_pkg::RESP_SUCCESS : tgt_m.resp_code;

endmodule

`default_nettype wire

// File: hdl/dmi_target.sv
// Debug register block
`timescale 1ns/100ps
`default_nettype none

module dmi_target (
  input  logic  clk_i,
  input  logic  rst_ni,
  dmi_if.slave  dmi_s,
  output logic  haltreq_o,
  output logic  dmactive_o
);

  logic                               accept;
  logic                               resp_done;
  logic                               pending_q;
  logic                               pending_d;
  logic                               req_ready_q;
  logic                               sel_ram_q;
  logic                               haltreq_q;
  logic                               dmactive_q;
  logic [dmi_pkg::DMI_ADDR_W-1:0]     buf_off;
  logic                               ctrl_hit;
  logic                               buf_hit;
  logic                               ram_rd;
  logic                               ram_wr;
  logic                               ctrl_wr;
  logic [dmi_pkg::DMI_DATA_W-1:0]     resp_data_d;
  logic [dmi_pkg::DMI_DATA_W-1:0]     resp_data_q;
  dmi_pkg::dmi_resp_e                 resp_code_d;
  dmi_pkg::dmi_resp_e                 resp_code_q;
  logic [dmi_pkg::DMI_DATA_W-1:0]     ram_rdata;
  dmi_pkg::dmi_word_u                 wr_word;
  dmi_pkg::dmi_word_u                 rd_word;

  // ----------------------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------------------
  assign accept    = dmi_s.req_valid & req_ready_q;
  assign resp_done = pending_q & dmi_s.resp_ready;

  // One item in flight, accept and completion never coincide
  assign pending_d = accept | (pending_q & ~resp_done);

  // ----------------------------------------------------------------------
  // Decode
  // ----------------------------------------------------------------------
  // Wraps for addresses below the base, so a single compare is enough
  assign buf_off  = dmi_s.req_addr - dmi_pkg::DATA_BASE_ADDR;
  assign buf_hit  = (buf_off < dmi_pkg::DATA_WORDS);
  assign ctrl_hit = (dmi_s.req_addr == dmi_pkg::DMCONTROL_ADDR);

  // Same word seen as control fields
  assign wr_word.raw  = dmi_s.req_data;
  assign rd_word.ctrl = '{haltreq: haltreq_q, reserved: '0, dmactive: dmactive_q};

  always_comb begin
    resp_code_d = dmi_pkg::RESP_SUCCESS;
    resp_data_d = '0;
    ram_rd      = 1'b0;
    ram_wr      = 1'b0;
    ctrl_wr     = 1'b0;
    case (dmi_s.req_op)
      dmi_pkg::OP_NOP: begin
      end
      dmi_pkg::OP_READ: begin
        if (ctrl_hit) begin
          resp_data_d = rd_word.raw;
        end else if (buf_hit) begin
          ram_rd = 1'b1;
        end else begin
          resp_code_d = dmi_pkg::RESP_FAILED;
        end
      end
      dmi_pkg::OP_WRITE: begin
        if (ctrl_hit) begin
          ctrl_wr = 1'b1;
        end else if (buf_hit) begin
          ram_wr = 1'b1;
        end else begin
          resp_code_d = dmi_pkg::RESP_FAILED;
        end
      end
      default: resp_code_d = dmi_pkg::RESP_FAILED;
    endcase
  end

  dmi_data_ram i_dmi_data_ram (
    .clk_i   ( clk_i                                ),
    .req_i   ( accept & (ram_rd | ram_wr)           ),
    .we_i    ( ram_wr                               ),
    .addr_i  ( buf_off[dmi_pkg::DATA_IDX_W-1:0]     ),
    .wdata_i ( dmi_s.req_data                       ),
    .rdata_o ( ram_rdata                            )
  );

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q   <= 1'b0;
      req_ready_q <= 1'b0;
      sel_ram_q   <= 1'b0;
      haltreq_q   <= 1'b0;
      dmactive_q  <= 1'b0;
    end else begin
      pending_q   <= pending_d;
      req_ready_q <= ~pending_d;
      if (accept) begin
        sel_ram_q <= ram_rd;
      end
      if (accept && ctrl_wr) begin
        haltreq_q  <= wr_word.ctrl.haltreq;
        dmactive_q <= wr_word.ctrl.dmactive;
      end
    end
  end

  // Response payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_data_q <= resp_data_d;
      resp_code_q <= resp_code_d;
    end
  end

  assign dmi_s.req_ready  = req_ready_q;
  assign dmi_s.resp_valid = pending_q;
  assign dmi_s.resp_data  = sel_ram_q ? ram_rdata : resp_data_q;
  assign dmi_s.resp_code  = resp_code_q;

  assign haltreq_o  = haltreq_q;
  assign dmactive_o = dmactive_q;

endmodule

`default_nettype wire

// File: project.f
hdl/dmi_pkg.sv
hdl/dmi_if.sv
hdl/dmi_source_mux.sv
hdl/dmi_data_ram.sv
hdl/dmi_target.sv
hdl/debug_req_gate.sv
hdl/dmi_harness_top.sv
testbench/dmi_harness_asserts.sv
testbench/tb_dmi_harness.sv

// File: testbench/dmi_harness_asserts.sv
// DMI harness protocol checks
`timescale 1ns/100ps
`default_nettype none

module dmi_harness_asserts #(
  parameter int unsigned DelayCycles = dmi_pkg::DELAY_CYCLES_DEFAULT
) (
  input logic                            clk_i,
  input logic                            rst_ni,
  input logic                            sel_jtag_i,
  input logic                            jtag_req_ready_i,
  input logic                            jtag_resp_valid_i,
  input logic [dmi_pkg::DMI_DATA_W-1:0]  jtag_resp_data_i,
  input logic [1:0]                      jtag_resp_code_i,
  input logic                            jtag_resp_ready_i,
  input logic                            dtm_req_ready_i,
  input logic                            dtm_resp_valid_i,
  input logic [dmi_pkg::DMI_DATA_W-1:0]  dtm_resp_data_i,
  input logic [1:0]                      dtm_resp_code_i,
  input logic                            dtm_resp_ready_i,
  input logic                            debug_req_i
);

  logic                           req_ready;
  logic                           resp_valid;
  logic                           resp_ready;
  logic [dmi_pkg::DMI_DATA_W-1:0] resp_data;
  logic [1:0]                     resp_code;
  int unsigned                    edges_q;
  bit                             failed;

  // Channel of the selected source
  assign req_ready  = sel_jtag_i ? jtag_req_ready_i  : dtm_req_ready_i;
  assign resp_valid = sel_jtag_i ? jtag_resp_valid_i : dtm_resp_valid_i;
  assign resp_ready = sel_jtag_i ? jtag_resp_ready_i : dtm_resp_ready_i;
  assign resp_data  = sel_jtag_i ? jtag_resp_data_i  : dtm_resp_data_i;
  assign resp_code  = sel_jtag_i ? jtag_resp_code_i  : dtm_resp_code_i;

  // Rising edges seen since reset, saturating at the hold-off length
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges_q <= 0;
    end else if (edges_q < DelayCycles) begin
      edges_q <= edges_q + 1;
    end
  end

  // ----------------------------------------------------------------------
  // Properties
  // ----------------------------------------------------------------------
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_data) && $stable(resp_code))
    else begin
      $error("Response changed or dropped under back-pressure");
      failed = 1'b1;
    end

  busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      resp_valid |-> !req_ready)
    else begin
      $error("Request ready while a response is pending");
      failed = 1'b1;
    end

  unselected_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
      sel_jtag_i ? !(dtm_req_ready_i || dtm_resp_valid_i)
                 : !(jtag_req_ready_i || jtag_resp_valid_i))
    else begin
      $error("Unselected source saw ready or a response");
      failed = 1'b1;
    end

  holdoff_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
      edges_q < DelayCycles |-> !debug_req_i)
    else begin
      $error("Debug request raised during the startup hold-off");
      failed = 1'b1;
    end

endmodule

bind dmi_harness_top dmi_harness_asserts #(
  .DelayCycles ( DelayCycles )
) i_asserts (
  .clk_i             ( clk_i             ),
  .rst_ni            ( rst_ni            ),
  .sel_jtag_i        ( sel_jtag_i        ),
  .jtag_req_ready_i  ( jtag_req_ready_o  ),
  .jtag_resp_valid_i ( jtag_resp_valid_o ),
  .jtag_resp_data_i  ( jtag_resp_data_o  ),
  .jtag_resp_code_i  ( jtag_resp_code_o  ),
  .jtag_resp_ready_i ( jtag_resp_ready_i ),
  .dtm_req_ready_i   ( dtm_req_ready_o   ),
  .dtm_resp_valid_i  ( dtm_resp_valid_o  ),
  .dtm_resp_data_i   ( dtm_resp_data_o   ),
  .dtm_resp_code_i   ( dtm_resp_code_o   ),
  .dtm_resp_ready_i  ( dtm_resp_ready_i  ),
  .debug_req_i       ( debug_req_o       )
);

`default_nettype wire

// File: testbench/tb_dmi_harness.sv
// DMI harness testbench
`timescale 1ns/100ps
`default_nettype none

module tb_dmi_harness;

  localparam int unsigned DelayCycles = 40;
  localparam int unsigned TimeoutNs   = (DelayCycles + 300 * 24) * 10;

  logic                           clk;
  logic                           rst_n;
  logic                           sel_jtag;
  logic                           jtag_req_valid;
  logic [dmi_pkg::DMI_ADDR_W-1:0] jtag_req_addr;
  logic [1:0]                     jtag_req_op;
  logic [dmi_pkg::DMI_DATA_W-1:0] jtag_req_data;
  logic                           jtag_req_ready;
  logic                           jtag_resp_valid;
  logic [dmi_pkg::DMI_DATA_W-1:0] jtag_resp_data;
  logic [1:0]                     jtag_resp_code;
  logic                           jtag_resp_ready;
  logic                           dtm_req_valid;
  logic [dmi_pkg::DMI_ADDR_W-1:0] dtm_req_addr;
  logic [1:0]                     dtm_req_op;
  logic [dmi_pkg::DMI_DATA_W-1:0] dtm_req_data;
  logic                           dtm_req_ready;
  logic                           dtm_resp_valid;
  logic [dmi_pkg::DMI_DATA_W-1:0] dtm_resp_data;
  logic [1:0]                     dtm_resp_code;
  logic                           dtm_resp_ready;
  logic                           dmactive;
  logic                           debug_req;

  // Reference model state
  logic [dmi_pkg::DMI_DATA_W-1:0] model_mem [dmi_pkg::DATA_WORDS];
  dmi_pkg::dmi_word_u             model_ctrl;
  dmi_pkg::dmi_word_u             wr_word;
  logic [dmi_pkg::DMI_DATA_W-1:0] exp_data;
  logic [1:0]                     exp_code;
  logic [31:0]                    lfsr;
  int unsigned                    edges;

  // Channel of the selected source
  wire                           req_valid_sel  = sel_jtag ? jtag_req_valid  : dtm_req_valid;
  wire                           req_ready_sel  = sel_jtag ? jtag_req_ready  : dtm_req_ready;
  wire [dmi_pkg::DMI_ADDR_W-1:0] req_addr_sel   = sel_jtag ? jtag_req_addr   : dtm_req_addr;
  wire [1:0]                     req_op_sel     = sel_jtag ? jtag_req_op     : dtm_req_op;
  wire [dmi_pkg::DMI_DATA_W-1:0] req_data_sel   = sel_jtag ? jtag_req_data   : dtm_req_data;
  wire                           resp_valid_sel = sel_jtag ? jtag_resp_valid : dtm_resp_valid;
  wire                           resp_ready_sel = sel_jtag ? jtag_resp_ready : dtm_resp_ready;
  wire [dmi_pkg::DMI_DATA_W-1:0] resp_data_sel  = sel_jtag ? jtag_resp_data  : dtm_resp_data;
  wire [1:0]                     resp_code_sel  = sel_jtag ? jtag_resp_code  : dtm_resp_code;

  dmi_harness_top #(
    .DelayCycles ( DelayCycles )
  ) i_dut (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .sel_jtag_i        ( sel_jtag        ),
    .jtag_req_valid_i  ( jtag_req_valid  ),
    .jtag_req_addr_i   ( jtag_req_addr   ),
    .jtag_req_op_i     ( jtag_req_op     ),
    .jtag_req_data_i   ( jtag_req_data   ),
    .jtag_req_ready_o  ( jtag_req_ready  ),
    .jtag_resp_valid_o ( jtag_resp_valid ),
    .jtag_resp_data_o  ( jtag_resp_data  ),
    .jtag_resp_code_o  ( jtag_resp_code  ),
    .jtag_resp_ready_i ( jtag_resp_ready ),
    .dtm_req_valid_i   ( dtm_req_valid   ),
    .dtm_req_addr_i    ( dtm_req_addr    ),
    .dtm_req_op_i      ( dtm_req_op      ),
    .dtm_req_data_i    ( dtm_req_data    ),
    .dtm_req_ready_o   ( dtm_req_ready   ),
    .dtm_resp_valid_o  ( dtm_resp_valid  ),
    .dtm_resp_data_o   ( dtm_resp_data   ),
    .dtm_resp_code_o   ( dtm_resp_code   ),
    .dtm_resp_ready_i  ( dtm_resp_ready  ),
    .dmactive_o        ( dmactive        ),
    .debug_req_o       ( debug_req       )
  );

  always #5 clk = ~clk;

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return bits;
  endfunction

  task automatic set_req(input logic v, input logic [6:0] a, input logic [1:0] op,
                         input logic [31:0] d);
    if (sel_jtag) begin
      jtag_req_valid = v;
      jtag_req_addr  = a;
      jtag_req_op    = op;
      jtag_req_data  = d;
    end else begin
      dtm_req_valid = v;
      dtm_req_addr  = a;
      dtm_req_op    = op;
      dtm_req_data  = d;
    end
  endtask

  task automatic set_resp_ready(input logic r);
    if (sel_jtag) begin
      jtag_resp_ready = r;
    end else begin
      dtm_resp_ready = r;
    end
  endtask

  // One request with a random response stall and idle gap
  task automatic run_txn(input logic [6:0] addr, input logic [1:0] op, input logic [31:0] data);
    int unsigned stall;
    int unsigned gap;
    stall = rand_bits(3);
    gap   = rand_bits(2);
    set_req(1'b1, addr, op, data);
    set_resp_ready(1'b0);
    do @(posedge clk); while (!req_ready_sel);
    #1;
    set_req(1'b0, '0, dmi_pkg::OP_NOP, '0);
    set_resp_ready(stall == 0);
    if (stall > 0) begin
      repeat (stall) @(posedge clk);
      #1;
      set_resp_ready(1'b1);
    end
    do @(posedge clk); while (!(resp_valid_sel && resp_ready_sel));
    #1;
    set_resp_ready(1'b0);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Fill every word, then mix random writes and reads
  task automatic buffer_test();
    logic [6:0] addr;
    logic [1:0] op;
    for (int unsigned i = 0; i < dmi_pkg::DATA_WORDS; i++) begin
      run_txn(7'(dmi_pkg::DATA_BASE_ADDR + i), dmi_pkg::OP_WRITE, rand_bits(32));
    end
    repeat (24) begin
      addr = 7'(dmi_pkg::DATA_BASE_ADDR + rand_bits(4));
      op   = rand_bits(1) ? dmi_pkg::OP_WRITE : dmi_pkg::OP_READ;
      run_txn(addr, op, rand_bits(32));
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && req_valid_sel && req_ready_sel) begin
      exp_data    = '0;
      exp_code    = dmi_pkg::RESP_SUCCESS;
      wr_word.raw = req_data_sel;
      if (req_op_sel == 2'd3) begin
        exp_code = dmi_pkg::RESP_FAILED;
      end else if (req_op_sel != dmi_pkg::OP_NOP) begin
        if (req_addr_sel == dmi_pkg::DMCONTROL_ADDR) begin
          if (req_op_sel == dmi_pkg::OP_READ) begin
            exp_data = model_ctrl.raw;
          end else begin
            model_ctrl.ctrl.haltreq  = wr_word.ctrl.haltreq;
            model_ctrl.ctrl.dmactive = wr_word.ctrl.dmactive;
          end
        end else if (req_addr_sel >= dmi_pkg::DATA_BASE_ADDR &&
                     req_addr_sel < dmi_pkg::DATA_BASE_ADDR + dmi_pkg::DATA_WORDS) begin
          if (req_op_sel == dmi_pkg::OP_READ) begin
            exp_data = model_mem[req_addr_sel - dmi_pkg::DATA_BASE_ADDR];
          end else begin
            model_mem[req_addr_sel - dmi_pkg::DATA_BASE_ADDR] = req_data_sel;
          end
        end else begin
          exp_code = dmi_pkg::RESP_FAILED;
        end
      end
    end
  end

  // Edges since reset release, saturating at the hold-off
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      edges <= 0;
    end else if (edges < DelayCycles) begin
      edges <= edges + 1;
    end
  end

  resp_check: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid_sel && resp_ready_sel |-> resp_data_sel == exp_data && resp_code_sel == exp_code)
    else report_failure($sformatf("Fail %0t: response %h code %0d, expected %h code %0d",
      $time, $sampled(resp_data_sel), $sampled(resp_code_sel), exp_data, exp_code));

  dmactive_check: assert property (@(posedge clk) disable iff (!rst_n)
      dmactive == model_ctrl.ctrl.dmactive)
    else report_failure($sformatf("Fail %0t: dmactive_o is %b", $time, $sampled(dmactive)));

  debug_req_check: assert property (@(posedge clk) disable iff (!rst_n)
      debug_req == (model_ctrl.ctrl.haltreq && edges >= DelayCycles))
    else report_failure($sformatf("Fail %0t: debug_req_o is %b", $time, $sampled(debug_req)));

  always @(posedge i_dut.i_asserts.failed) begin
    report_failure($sformatf("Fail %0t: a protocol assertion in the bound checker failed",
      $time));
  end

  initial begin
    #(TimeoutNs);
    report_failure("Simulation timed out before all tests finished");
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------
  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    sel_jtag        = 1'b1;
    lfsr            = 32'd79361;
    model_ctrl.raw  = '0;
    jtag_req_valid  = 1'b0;
    jtag_req_addr   = '0;
    jtag_req_op     = '0;
    jtag_req_data   = '0;
    jtag_resp_ready = 1'b0;
    dtm_req_valid   = 1'b0;
    dtm_req_addr    = '0;
    dtm_req_op      = '0;
    dtm_req_data    = '0;
    dtm_resp_ready  = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Halt request straight after reset, held back by the gate
    run_txn(dmi_pkg::DMCONTROL_ADDR, dmi_pkg::OP_WRITE, 32'h8000_0001);
    buffer_test();
    while (edges < DelayCycles) begin
      @(posedge clk);
      #1;
    end
    repeat (4) begin
      @(posedge clk);
      #1;
    end

    // Control register with random reserved bits
    repeat (6) begin
      run_txn(dmi_pkg::DMCONTROL_ADDR, dmi_pkg::OP_WRITE, rand_bits(32));
      run_txn(dmi_pkg::DMCONTROL_ADDR, dmi_pkg::OP_READ, '0);
    end
    run_txn(dmi_pkg::DMCONTROL_ADDR, dmi_pkg::OP_WRITE, 32'h0000_0001);
    run_txn(dmi_pkg::DMCONTROL_ADDR, dmi_pkg::OP_READ, '0);

    // DTM side, with a JTAG request left waiting
    sel_jtag        = 1'b0;
    jtag_req_valid  = 1'b1;
    jtag_req_addr   = dmi_pkg::DATA_BASE_ADDR;
    jtag_req_op     = dmi_pkg::OP_READ;
    jtag_resp_ready = 1'b1;
    buffer_test();

    // Unmapped addresses, reserved op code and NOPs
    run_txn(7'h00, dmi_pkg::OP_READ, '0);
    run_txn(7'h1F, dmi_pkg::OP_WRITE, rand_bits(32));
    run_txn(7'h30, dmi_pkg::OP_READ, '0);
    run_txn(7'h7F, dmi_pkg::OP_WRITE, rand_bits(32));
    run_txn(dmi_pkg::DMCONTROL_ADDR, 2'd3, rand_bits(32));
    run_txn(7'h23, 2'd3, rand_bits(32));
    repeat (4) run_txn(7'(rand_bits(7)), dmi_pkg::OP_NOP, rand_bits(32));
    jtag_req_valid = 1'b0;
    repeat (4) @(posedge clk);

    if (i_dut.i_asserts.failed) begin
      report_failure("A protocol assertion failed before the end of the run");
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire
